//--- source/cache_config.svh
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

// Processor port widths
`define CACHE_ADDR_WIDTH 32
`define CACHE_DATA_WIDTH 32
`define CACHE_STRB_WIDTH (`CACHE_DATA_WIDTH / 8)

// Direct-mapped geometry with one word per line
`define CACHE_NUM_SETS 4
`define CACHE_OFFSET_BITS 2
`define CACHE_INDEX_BITS ($clog2(`CACHE_NUM_SETS))
`define CACHE_TAG_BITS (`CACHE_ADDR_WIDTH - `CACHE_INDEX_BITS - `CACHE_OFFSET_BITS)

// Backing memory depth, higher address bits alias
`define MEM_NUM_WORDS 256
`define MEM_INDEX_BITS ($clog2(`MEM_NUM_WORDS))

`endif

//--- source/cache_pkg.sv
package cache_pkg;

`include "cache_config.svh"

  // Byte address and data word
  typedef logic [`CACHE_ADDR_WIDTH-1:0] addr_t;
  typedef logic [`CACHE_DATA_WIDTH-1:0] data_t;

  // One enable per data byte
  typedef logic [`CACHE_STRB_WIDTH-1:0] strb_t;

  // Address fields above the byte offset
  typedef logic [`CACHE_INDEX_BITS-1:0] index_t;
  typedef logic [`CACHE_TAG_BITS-1:0] tag_t;

  // Controller states
  typedef enum logic [1:0] {
    available,
    await_writeback,
    await_fill,
    await_proc_ready
  } cache_state_e;

endpackage

//--- source/cache_store.sv
`timescale 1ns/1ns
`include "cache_config.svh"

module cache_store (
  input  logic             ACLK,
  input  logic             ARESETn,
  input  cache_pkg::addr_t lookup_addr,
  output logic             hit,
  output cache_pkg::data_t line_data,
  output logic             victim_dirty,
  output cache_pkg::addr_t victim_addr,
  input  logic             fill_en,
  input  cache_pkg::data_t fill_data,
  input  logic             wr_en,
  input  cache_pkg::data_t wr_data,
  input  cache_pkg::strb_t wr_strb
);

  // Per-set line storage
  cache_pkg::data_t data_q [`CACHE_NUM_SETS];
  cache_pkg::tag_t  tag_q  [`CACHE_NUM_SETS];
  logic [`CACHE_NUM_SETS-1:0] valid_q;
  logic [`CACHE_NUM_SETS-1:0] dirty_q;

  cache_pkg::index_t idx;
  cache_pkg::tag_t   lookup_tag;

  assign idx        = lookup_addr[`CACHE_OFFSET_BITS +: `CACHE_INDEX_BITS];
  assign lookup_tag = lookup_addr[`CACHE_ADDR_WIDTH-1 -: `CACHE_TAG_BITS];

  assign hit       = valid_q[idx] && (tag_q[idx] == lookup_tag);
  assign line_data = data_q[idx];

  // Resident line of the indexed set, as a writeback candidate
  assign victim_dirty = valid_q[idx] && dirty_q[idx];
  assign victim_addr  = {tag_q[idx], idx, {`CACHE_OFFSET_BITS{1'b0}}};

  always_ff @(posedge ACLK) begin
    if (!ARESETn) begin
      valid_q <= '0;
      dirty_q <= '0;
    end else if (fill_en) begin
      valid_q[idx] <= 1'b1;
      dirty_q[idx] <= 1'b0;
    end else if (wr_en) begin
      dirty_q[idx] <= 1'b1;
    end
  end

  always_ff @(posedge ACLK) begin
    if (fill_en) begin
      data_q[idx] <= fill_data;
      tag_q[idx]  <= lookup_tag;
    end else if (wr_en) begin
      // Merge only the enabled bytes
      for (int i = 0; i < `CACHE_STRB_WIDTH; i++) begin
        if (wr_strb[i]) begin
          data_q[idx][8*i +: 8] <= wr_data[8*i +: 8];
        end
      end
    end
  end

  // Fill and byte merge are issued in separate cycles by the controller
  a_fill_wr_exclusive: assert property (@(posedge ACLK) disable iff (!ARESETn)
    !(fill_en && wr_en));

endmodule

//--- source/cache_ctrl.sv
`timescale 1ns/1ns
`include "cache_config.svh"

module cache_ctrl (
  input  logic             ACLK,
  input  logic             ARESETn,
  // Processor port
  input  logic             ar_valid,
  output logic             ar_ready,
  input  cache_pkg::addr_t ar_addr,
  output logic             r_valid,
  input  logic             r_ready,
  output cache_pkg::data_t r_data,
  input  logic             aw_valid,
  output logic             aw_ready,
  input  cache_pkg::addr_t aw_addr,
  input  logic             w_valid,
  output logic             w_ready,
  input  cache_pkg::data_t w_data,
  input  cache_pkg::strb_t w_strb,
  output logic             b_valid,
  input  logic             b_ready,
  // Line store
  output cache_pkg::addr_t lookup_addr,
  input  logic             hit,
  input  cache_pkg::data_t line_data,
  input  logic             victim_dirty,
  input  cache_pkg::addr_t victim_addr,
  output logic             fill_en,
  output cache_pkg::data_t fill_data,
  output logic             wr_en,
  output cache_pkg::data_t wr_data,
  output cache_pkg::strb_t wr_strb,
  // Backing memory
  output logic             mem_ar_valid,
  input  logic             mem_ar_ready,
  output cache_pkg::addr_t mem_ar_addr,
  input  logic             mem_r_valid,
  input  cache_pkg::data_t mem_r_data,
  output logic             mem_aw_valid,
  input  logic             mem_aw_ready,
  output cache_pkg::addr_t mem_aw_addr,
  output cache_pkg::data_t mem_w_data,
  input  logic             mem_b_valid
);

  cache_pkg::cache_state_e state_q;
  cache_pkg::cache_state_e state_d;

  // Latched miss request
  cache_pkg::addr_t miss_addr;
  logic             miss_is_read;
  cache_pkg::data_t miss_wdata;
  cache_pkg::strb_t miss_wstrb;

  logic idle;
  logic in_fill;
  logic rd_req;
  logic wr_req;
  logic miss_start;
  logic wb_done;
  logic issue_fill;
  logic rd_done;

  assign idle     = (state_q == cache_pkg::available);
  assign in_fill  = (state_q == cache_pkg::await_fill);
  assign ar_ready = idle;
  assign aw_ready = idle;
  assign w_ready  = idle;

  assign rd_req = ar_valid && ar_ready;
  assign wr_req = aw_valid && aw_ready && w_valid && w_ready;

  // Lookup follows the incoming request while idle, the latched miss otherwise
  always_comb begin
    if (!idle)
      lookup_addr = miss_addr;
    else if (ar_valid)
      lookup_addr = ar_addr;
    else
      lookup_addr = aw_addr;
  end

  assign miss_start = idle && (rd_req || wr_req) && !hit;
  assign wb_done    = (state_q == cache_pkg::await_writeback) && mem_b_valid;
  // Clean victim goes straight to the fill
  assign issue_fill = (miss_start && !victim_dirty) || wb_done;

  assign fill_en   = in_fill && mem_r_valid;
  assign fill_data = mem_r_data;
  assign rd_done   = (idle && rd_req && hit) || (fill_en && miss_is_read);

  // A write miss merges one cycle after its fill, when the new line hits
  assign wr_en   = (idle && wr_req && hit) ||
                   (in_fill && !mem_r_valid && !miss_is_read && hit);
  assign wr_data = idle ? w_data : miss_wdata;
  assign wr_strb = idle ? w_strb : miss_wstrb;

  always_comb begin
    state_d = state_q;
    case (state_q)
      cache_pkg::available: begin
        if (miss_start)
          state_d = victim_dirty ? cache_pkg::await_writeback : cache_pkg::await_fill;
        else if (rd_req || wr_req)
          state_d = cache_pkg::await_proc_ready;
      end
      cache_pkg::await_writeback: begin
        if (wb_done)
          state_d = cache_pkg::await_fill;
      end
      cache_pkg::await_fill: begin
        if (rd_done || wr_en)
          state_d = cache_pkg::await_proc_ready;
      end
      cache_pkg::await_proc_ready: begin
        // Held here until the processor takes the response
        if ((r_valid && r_ready) || (b_valid && b_ready))
          state_d = cache_pkg::available;
      end
      default: state_d = cache_pkg::available;
    endcase
  end

  always_ff @(posedge ACLK) begin
    if (!ARESETn) begin
      state_q      <= cache_pkg::available;
      r_valid      <= 1'b0;
      b_valid      <= 1'b0;
      mem_ar_valid <= 1'b0;
      mem_aw_valid <= 1'b0;
      miss_is_read <= 1'b0;
    end else begin
      state_q <= state_d;
      if (rd_done)
        r_valid <= 1'b1;
      else if (r_ready)
        r_valid <= 1'b0;
      if (wr_en)
        b_valid <= 1'b1;
      else if (b_ready)
        b_valid <= 1'b0;
      if (issue_fill)
        mem_ar_valid <= 1'b1;
      else if (mem_ar_ready)
        mem_ar_valid <= 1'b0;
      if (miss_start && victim_dirty)
        mem_aw_valid <= 1'b1;
      else if (mem_aw_ready)
        mem_aw_valid <= 1'b0;
      if (miss_start)
        miss_is_read <= rd_req;
    end
  end

  always_ff @(posedge ACLK) begin
    if (rd_done)
      r_data <= idle ? line_data : mem_r_data;
    if (miss_start) begin
      miss_addr  <= lookup_addr;
      miss_wdata <= w_data;
      miss_wstrb <= w_strb;
    end
    // Victim leaves as a full word
    if (miss_start && victim_dirty) begin
      mem_aw_addr <= victim_addr;
      mem_w_data  <= line_data;
    end
    if (issue_fill)
      mem_ar_addr <= lookup_addr;
  end

  a_single_request: assert property (@(posedge ACLK) disable iff (!ARESETn)
    !(ar_valid && (aw_valid || w_valid)));

  a_ar_aligned: assert property (@(posedge ACLK) disable iff (!ARESETn)
    ar_valid |-> (ar_addr[`CACHE_OFFSET_BITS-1:0] == '0));

  a_aw_aligned: assert property (@(posedge ACLK) disable iff (!ARESETn)
    aw_valid |-> (aw_addr[`CACHE_OFFSET_BITS-1:0] == '0));

endmodule

//--- source/backing_mem.sv
`timescale 1ns/1ns
`include "cache_config.svh"

module backing_mem (
  input  logic             ACLK,
  input  logic             ARESETn,
  input  logic             mem_ar_valid,
  output logic             mem_ar_ready,
  input  cache_pkg::addr_t mem_ar_addr,
  output logic             mem_r_valid,
  output cache_pkg::data_t mem_r_data,
  input  logic             mem_aw_valid,
  output logic             mem_aw_ready,
  input  cache_pkg::addr_t mem_aw_addr,
  input  cache_pkg::data_t mem_w_data,
  output logic             mem_b_valid
);

  cache_pkg::data_t mem_array [`MEM_NUM_WORDS];

  logic [`MEM_INDEX_BITS-1:0] rd_index;
  logic [`MEM_INDEX_BITS-1:0] wr_index;

  // Word address, upper bits alias
  assign rd_index = mem_ar_addr[`CACHE_OFFSET_BITS +: `MEM_INDEX_BITS];
  assign wr_index = mem_aw_addr[`CACHE_OFFSET_BITS +: `MEM_INDEX_BITS];

  initial begin
    for (int i = 0; i < `MEM_NUM_WORDS; i++) begin
      mem_array[i] = '0;
    end
  end

  always_ff @(posedge ACLK) begin
    if (!ARESETn) begin
      mem_ar_ready <= 1'b0;
      mem_aw_ready <= 1'b0;
      mem_r_valid  <= 1'b0;
      mem_b_valid  <= 1'b0;
    end else begin
      mem_ar_ready <= 1'b1;
      mem_aw_ready <= 1'b1;
      // Single-cycle responses
      mem_r_valid  <= mem_ar_valid && mem_ar_ready;
      mem_b_valid  <= mem_aw_valid && mem_aw_ready;
    end
  end

  always_ff @(posedge ACLK) begin
    if (mem_ar_valid && mem_ar_ready)
      mem_r_data <= mem_array[rd_index];
    if (mem_aw_valid && mem_aw_ready)
      mem_array[wr_index] <= mem_w_data;
  end

  // Writeback is acknowledged before the fill read goes out
  a_resp_exclusive: assert property (@(posedge ACLK) disable iff (!ARESETn)
    !(mem_r_valid && mem_b_valid));

endmodule

//--- source/cache_top.sv
`timescale 1ns/1ns

module cache_top (
  input  logic             ACLK,
  input  logic             ARESETn,
  input  logic             ar_valid,
  output logic             ar_ready,
  input  cache_pkg::addr_t ar_addr,
  output logic             r_valid,
  input  logic             r_ready,
  output cache_pkg::data_t r_data,
  input  logic             aw_valid,
  output logic             aw_ready,
  input  cache_pkg::addr_t aw_addr,
  input  logic             w_valid,
  output logic             w_ready,
  input  cache_pkg::data_t w_data,
  input  cache_pkg::strb_t w_strb,
  output logic             b_valid,
  input  logic             b_ready
);

  // Controller to line store
  cache_pkg::addr_t lookup_addr;
  logic             hit;
  cache_pkg::data_t line_data;
  logic             victim_dirty;
  cache_pkg::addr_t victim_addr;
  logic             fill_en;
  cache_pkg::data_t fill_data;
  logic             wr_en;
  cache_pkg::data_t wr_data;
  cache_pkg::strb_t wr_strb;

  // Controller to backing memory
  logic             mem_ar_valid;
  logic             mem_ar_ready;
  cache_pkg::addr_t mem_ar_addr;
  logic             mem_r_valid;
  cache_pkg::data_t mem_r_data;
  logic             mem_aw_valid;
  logic             mem_aw_ready;
  cache_pkg::addr_t mem_aw_addr;
  cache_pkg::data_t mem_w_data;
  logic             mem_b_valid;

  cache_ctrl u_ctrl (.*);

  cache_store u_store (.*);

  backing_mem u_mem (.*);

endmodule

//--- testbench/cache_checker.sv
`timescale 1ns/1ns

module cache_checker (
  input  logic             ACLK,
  input  logic             ARESETn,
  input  logic             ar_valid,
  input  logic             ar_ready,
  input  logic             aw_ready,
  input  logic             w_ready,
  input  logic             r_valid,
  input  logic             r_ready,
  input  cache_pkg::data_t r_data,
  input  logic             b_valid,
  input  logic             b_ready,
  input  cache_pkg::data_t exp_r_data,
  input  logic             check_lat,
  output int               error_count,
  output int               check_count
);

  logic             after_reset;
  logic             held_r;
  logic             held_b;
  cache_pkg::data_t held_r_data;
  logic             lat_pending;
  int               lat_cycles;

  task automatic note_failure(input string msg);
    $display("ERROR: %s", msg);
    error_count++;
  endtask

  initial begin
    error_count = 0;
    check_count = 0;
  end

  always @(posedge ACLK) begin
    if (!ARESETn) begin
      after_reset <= 1'b1;
      held_r      <= 1'b0;
      held_b      <= 1'b0;
      lat_pending <= 1'b0;
      lat_cycles  <= 0;
    end else begin
      // Port levels on the first edge out of reset
      if (after_reset) begin
        after_reset <= 1'b0;
        check_count++;
        if (!(ar_ready && aw_ready && w_ready))
          note_failure("request ready low after reset");
        if (r_valid || b_valid)
          note_failure("response valid high after reset");
      end

      // Every completed read transfer
      if (r_valid && r_ready) begin
        check_count++;
        if (r_data !== exp_r_data) begin
          $display("MISMATCH r_data expected 0x%08h actual 0x%08h", exp_r_data, r_data);
          error_count++;
        end
      end

      // Responses held under back-pressure
      if (held_r) begin
        if (!r_valid)
          note_failure("r_valid dropped before r_ready was given");
        else if (r_data !== held_r_data) begin
          $display("MISMATCH r_data held expected 0x%08h actual 0x%08h", held_r_data, r_data);
          error_count++;
        end
      end
      if (held_b && !b_valid)
        note_failure("b_valid dropped before b_ready was given");
      held_r      <= r_valid && !r_ready;
      held_r_data <= r_data;
      held_b      <= b_valid && !b_ready;

      if ((r_valid || b_valid) && (ar_ready || aw_ready || w_ready))
        note_failure("request ready high while a response is pending");

      // Read hit latency, counted from the accepting edge
      if (ar_valid && ar_ready) begin
        lat_pending <= check_lat;
        lat_cycles  <= 1;
      end else if (lat_pending) begin
        if (r_valid) begin
          check_count++;
          lat_pending <= 1'b0;
          if (lat_cycles != 1) begin
            $display("MISMATCH r_valid latency expected 0x1 actual 0x%0h", lat_cycles);
            error_count++;
          end
        end else begin
          lat_cycles <= lat_cycles + 1;
        end
      end
    end
  end

endmodule

//--- testbench/tb_cache.sv
`timescale 1ns/1ns

module tb_cache;

  localparam int TIMEOUT_CYCLES = 100;
  localparam int WINDOW_WORDS   = 16;
  localparam int NUM_RANDOM_OPS = 300;
  localparam cache_pkg::addr_t WINDOW_BASE = 32'h0000_0200;

  logic             ACLK;
  logic             ARESETn;
  logic             ar_valid;
  logic             ar_ready;
  cache_pkg::addr_t ar_addr;
  logic             r_valid;
  logic             r_ready;
  cache_pkg::data_t r_data;
  logic             aw_valid;
  logic             aw_ready;
  cache_pkg::addr_t aw_addr;
  logic             w_valid;
  logic             w_ready;
  cache_pkg::data_t w_data;
  cache_pkg::strb_t w_strb;
  logic             b_valid;
  logic             b_ready;

  cache_pkg::data_t exp_r_data;
  logic             check_lat;
  int               checker_errors;
  int               checker_checks;

  // Expected contents of the address window
  cache_pkg::data_t model_mem [WINDOW_WORDS];

  bit timed_out;
  int tests_run;
  int failed_tests;
  int errors_at_start;

  cache_top UUT (.*);

  cache_checker u_checker (
    .ACLK        (ACLK),
    .ARESETn     (ARESETn),
    .ar_valid    (ar_valid),
    .ar_ready    (ar_ready),
    .aw_ready    (aw_ready),
    .w_ready     (w_ready),
    .r_valid     (r_valid),
    .r_ready     (r_ready),
    .r_data      (r_data),
    .b_valid     (b_valid),
    .b_ready     (b_ready),
    .exp_r_data  (exp_r_data),
    .check_lat   (check_lat),
    .error_count (checker_errors),
    .check_count (checker_checks)
  );

  initial begin
    ACLK = 1'b0;
    forever #10 ACLK = ~ACLK;
  end

  function automatic cache_pkg::addr_t window_addr(input int slot);
    return WINDOW_BASE + cache_pkg::addr_t'((slot % WINDOW_WORDS) * 4);
  endfunction

  function automatic int word_slot(input cache_pkg::addr_t addr);
    return int'((addr - WINDOW_BASE) >> 2);
  endfunction

  // Byte-lane merge of a write into the expected word
  function automatic void model_write(input cache_pkg::addr_t addr,
                                      input cache_pkg::data_t data,
                                      input cache_pkg::strb_t strb);
    cache_pkg::data_t mask;
    for (int b = 0; b < $bits(cache_pkg::strb_t); b++)
      mask[8*b +: 8] = {8{strb[b]}};
    model_mem[word_slot(addr)] = (model_mem[word_slot(addr)] & ~mask) | (data & mask);
  endfunction

  function automatic bit port_level(input bit is_write, input bit is_resp);
    if (is_resp)
      return is_write ? b_valid : r_valid;
    return is_write ? (aw_ready && w_ready) : ar_ready;
  endfunction

  // Levels are sampled on the falling edge, away from the updates
  task automatic wait_for(input bit is_write, input bit is_resp, input string what);
    int cycles;
    cycles = 0;
    @(negedge ACLK);
    while (!port_level(is_write, is_resp) && cycles < TIMEOUT_CYCLES && !timed_out) begin
      cycles++;
      @(negedge ACLK);
    end
    if (!port_level(is_write, is_resp) && !timed_out) begin
      $display("ERROR: gave up after %0d cycles waiting for %s", TIMEOUT_CYCLES, what);
      timed_out = 1'b1;
    end
  endtask

  task automatic take_resp(input bit is_write, input int delay);
    if (!timed_out) begin
      if (delay > 0) begin
        repeat (delay) @(posedge ACLK);
        if (is_write)
          b_ready <= 1'b1;
        else
          r_ready <= 1'b1;
      end
      @(posedge ACLK);
      r_ready <= 1'b0;
      b_ready <= 1'b0;
    end
  endtask

  task automatic do_read(input cache_pkg::addr_t addr, input int delay);
    @(posedge ACLK);
    ar_valid   <= 1'b1;
    ar_addr    <= addr;
    r_ready    <= (delay == 0);
    exp_r_data <= model_mem[word_slot(addr)];
    wait_for(1'b0, 1'b0, "ar_ready");
    @(posedge ACLK);
    ar_valid <= 1'b0;
    wait_for(1'b0, 1'b1, "r_valid");
    take_resp(1'b0, delay);
  endtask

  task automatic do_write(input cache_pkg::addr_t addr, input cache_pkg::data_t data,
                          input cache_pkg::strb_t strb, input int delay);
    @(posedge ACLK);
    aw_valid <= 1'b1;
    w_valid  <= 1'b1;
    aw_addr  <= addr;
    w_data   <= data;
    w_strb   <= strb;
    b_ready  <= (delay == 0);
    wait_for(1'b1, 1'b0, "aw_ready and w_ready");
    @(posedge ACLK);
    aw_valid <= 1'b0;
    w_valid  <= 1'b0;
    model_write(addr, data, strb);
    wait_for(1'b1, 1'b1, "b_valid");
    take_resp(1'b1, delay);
  endtask

  task automatic start_test();
    errors_at_start = checker_errors;
  endtask

  task automatic end_test(input int num, input string name);
    int errs;
    @(negedge ACLK);
    errs = checker_errors - errors_at_start;
    tests_run++;
    if (errs == 0 && !timed_out) begin
      $display("test %0d %s: ok", num, name);
    end else begin
      failed_tests++;
      $display("test %0d %s: failed, %0d errors", num, name, errs);
    end
  endtask

  initial begin
    cache_pkg::addr_t addr_a;
    cache_pkg::addr_t addr_b;
    int unsigned      seed_val;
    seed_val = $urandom(32'hfae2);
    ARESETn    = 1'b0;
    ar_valid   = 1'b0;
    ar_addr    = '0;
    r_ready    = 1'b0;
    aw_valid   = 1'b0;
    aw_addr    = '0;
    w_valid    = 1'b0;
    w_data     = '0;
    w_strb     = '0;
    b_ready    = 1'b0;
    exp_r_data = '0;
    check_lat  = 1'b0;
    timed_out    = 1'b0;
    tests_run    = 0;
    failed_tests = 0;
    for (int i = 0; i < WINDOW_WORDS; i++)
      model_mem[i] = '0;

    start_test();
    repeat (2) @(posedge ACLK);
    ARESETn <= 1'b1;
    do_read(window_addr(5), 0);
    end_test(1, "reset state and cold read");

    // Hit right after allocation, then a miss after eviction
    start_test();
    addr_a = window_addr(1);
    addr_b = window_addr(5);
    do_write(addr_a, $urandom, 4'hf, 0);
    do_read(addr_a, 0);
    do_read(addr_b, 0);
    do_read(addr_a, 1);
    end_test(2, "full word write and read back");

    start_test();
    addr_a = window_addr(2);
    do_write(addr_a, $urandom, 4'hf, 0);
    do_write(addr_a, $urandom, 4'b0101, 1);
    do_read(addr_a, 0);
    do_write(addr_a, $urandom, 4'b1000, 0);
    do_read(addr_a, 2);
    end_test(3, "partial strobes");

    // Same set, different tags
    start_test();
    addr_a = window_addr(3);
    addr_b = window_addr(7);
    do_write(addr_a, $urandom, 4'hf, 0);
    do_write(addr_b, $urandom, 4'hf, 0);
    do_read(addr_a, 0);
    do_read(addr_b, 1);
    end_test(4, "dirty victim writeback");

    start_test();
    addr_a = window_addr(9);
    addr_b = window_addr(13);
    do_write(addr_a, $urandom, 4'hf, 3);
    do_read(addr_a, 3);
    do_read(addr_b, 2);
    do_write(addr_b, $urandom, 4'h6, 3);
    end_test(5, "response hold under back-pressure");

    start_test();
    addr_a = window_addr(4);
    addr_b = window_addr(8);
    do_write(addr_a, $urandom, 4'hf, 0);
    check_lat <= 1'b1;
    do_read(addr_a, 0);
    do_write(addr_b, $urandom, 4'hf, 0);
    do_read(addr_b, 0);
    check_lat <= 1'b0;
    end_test(6, "read hit latency after write");

    start_test();
    for (int n = 0; n < NUM_RANDOM_OPS; n++) begin
      addr_a = window_addr($urandom_range(0, WINDOW_WORDS - 1));
      if ($urandom_range(0, 1))
        do_write(addr_a, $urandom, $urandom_range(0, 15), $urandom_range(0, 3));
      else
        do_read(addr_a, $urandom_range(0, 3));
    end
    end_test(7, "random mixed traffic");

    $display("tests %0d, failed %0d, checks %0d, errors %0d, timeout %0d",
             tests_run, failed_tests, checker_checks, checker_errors, timed_out);
    if (failed_tests == 0 && checker_errors == 0 && !timed_out) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- sim.f
+incdir+source
source/cache_pkg.sv
source/cache_store.sv
source/cache_ctrl.sv
source/backing_mem.sv
source/cache_top.sv
testbench/cache_checker.sv
testbench/tb_cache.sv

//--- Bender.yml
package:
  name: dm_cache

sources:
  - include_dirs:
      - source
    files:
      - source/cache_pkg.sv
      - source/cache_store.sv
      - source/cache_ctrl.sv
      - source/backing_mem.sv
      - source/cache_top.sv
  - target: test
    files:
      - testbench/cache_checker.sv
      - testbench/tb_cache.sv
